// ==== sim.f ====
source/sl_flit_pkg.sv
source/sl_link_pkg.sv
source/sl_noc_bridge.sv
source/sl_data_link.sv
source/sl_rx_fifo.sv
source/sl_physical.sv
source/serial_link.sv
verif/sl_checker.sv
verif/tb_serial_link.sv

// ==== verif/tb_serial_link.sv ====
/*
 * Testbench for the serial link
 * Loops the lanes back into the DUT and applies a stimulus table,
 * the checker does all comparing
 */

module tb_serial_link
  import sl_flit_pkg::*;
  import sl_link_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumLanes    = 4;
  localparam int RxFifoDepth = 4;
  localparam int ClkPeriod   = 8;
  localparam int ResetCycles = 8;
  localparam int NumEntries  = 10;
  localparam int HoldCycles  = 12;
  localparam int MaxClkDiv   = 4;
  // Up to three flits on each of the two channels
  localparam int MaxFlits    = 6;
  localparam int NumBeats    = PayloadWidth / (2 * NumLanes);
  localparam int TimeoutNs   = NumEntries * MaxFlits * NumBeats * 2 * MaxClkDiv * ClkPeriod * 4
                               + ResetCycles * ClkPeriod;

  typedef struct packed {
    chan_e      chan;
    logic       both;
    clk_div_t   clk_div;
    logic       tx_en;
    logic [1:0] burst;
    logic [7:0] stall;
  } entry_t;

  logic                clk;
  logic                reset;
  phy_cfg_t            cfg;
  noc_chan_t           req_in;
  noc_chan_t           rsp_in;
  logic                req_in_ready;
  logic                rsp_in_ready;
  noc_chan_t           req_out;
  noc_chan_t           rsp_out;
  logic                req_out_ready;
  logic                rsp_out_ready;
  logic                lane_clk;
  logic [NumLanes-1:0] lanes;
  int                  errors;
  int                  accepted;
  int                  delivered;
  integer              seed;
  int                  idx;
  entry_t              stim [NumEntries];

  initial clk = 1'b0;
  always #(ClkPeriod / 2) clk = ~clk;

  serial_link #(
    .NumLanes    ( NumLanes    ),
    .RxFifoDepth ( RxFifoDepth )
  ) dut0 (
    .clk_i         ( clk           ),
    .reset_i       ( reset         ),
    .cfg_i         ( cfg           ),
    .req_i         ( req_in        ),
    .rsp_i         ( rsp_in        ),
    .req_ready_o   ( req_in_ready  ),
    .rsp_ready_o   ( rsp_in_ready  ),
    .req_o         ( req_out       ),
    .rsp_o         ( rsp_out       ),
    .req_ready_i   ( req_out_ready ),
    .rsp_ready_i   ( rsp_out_ready ),
    .ddr_rcv_clk_o ( lane_clk      ),
    .ddr_o         ( lanes         ),
    .ddr_rcv_clk_i ( lane_clk      ),
    .ddr_i         ( lanes         )
  );

  sl_checker #(
    .NumLanes ( NumLanes )
  ) chk0 (
    .clk_i           ( clk           ),
    .reset_i         ( reset         ),
    .cfg_i           ( cfg           ),
    .in_req_i        ( req_in        ),
    .in_rsp_i        ( rsp_in        ),
    .in_req_ready_i  ( req_in_ready  ),
    .in_rsp_ready_i  ( rsp_in_ready  ),
    .out_req_i       ( req_out       ),
    .out_rsp_i       ( rsp_out       ),
    .out_req_ready_i ( req_out_ready ),
    .out_rsp_ready_i ( rsp_out_ready ),
    .lane_clk_i      ( lane_clk      ),
    .errors_o        ( errors        ),
    .accepted_o      ( accepted      ),
    .delivered_o     ( delivered     )
  );

  //////////////////////
  // Stimulus table
  //////////////////////

  function automatic entry_t make_entry(input chan_e ch, input logic both, input int div,
                                        input logic en, input int burst, input int stall);
    entry_t e;
    e.chan    = ch;
    e.both    = both;
    e.clk_div = clk_div_t'(div);
    e.tx_en   = en;
    e.burst   = 2'(burst);
    e.stall   = 8'(stall);
    return e;
  endfunction

  // Channel, both, clk_div, tx_en, flits per channel, output stall cycles
  task automatic fill_table();
    stim[0] = make_entry(CHAN_REQ, 1'b0, 1, 1'b1, 1, 0);
    stim[1] = make_entry(CHAN_RSP, 1'b0, 1, 1'b1, 2, 0);
    stim[2] = make_entry(CHAN_REQ, 1'b1, 2, 1'b1, 2, 0);
    stim[3] = make_entry(CHAN_RSP, 1'b0, 3, 1'b1, 1, 0);
    stim[4] = make_entry(CHAN_REQ, 1'b0, 4, 1'b1, 2, 0);
    // Output stall spanning about three payloads
    stim[5] = make_entry(CHAN_REQ, 1'b0, 2, 1'b1, 3, 70);
    stim[6] = make_entry(CHAN_RSP, 1'b1, 1, 1'b1, 3, 30);
    stim[7] = make_entry(CHAN_REQ, 1'b0, 3, 1'b0, 1, 0);
    stim[8] = make_entry(CHAN_RSP, 1'b1, 2, 1'b0, 1, 0);
    stim[9] = make_entry(CHAN_REQ, 1'b1, 4, 1'b1, 3, 10);
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic send_flits(input chan_e ch, input int count);
    int    i;
    flit_t d;
    logic  taken;
    for (i = 0; i < count; i++) begin
      d = flit_t'($random(seed));
      if (ch == CHAN_REQ) begin
        req_in.valid = 1'b1;
        req_in.data  = d;
      end else begin
        rsp_in.valid = 1'b1;
        rsp_in.data  = d;
      end
      // Ready is looked at halfway to the rising edge, where it has settled
      taken = 1'b0;
      while (!taken) begin
        #(ClkPeriod / 4);
        taken = (ch == CHAN_REQ) ? req_in_ready : rsp_in_ready;
        @(negedge clk);
      end
    end
    if (ch == CHAN_REQ) req_in.valid = 1'b0;
    else rsp_in.valid = 1'b0;
  endtask

  task automatic wait_idle();
    while (delivered != accepted || req_in.valid || rsp_in.valid || req_in_ready
           || rsp_in_ready || lane_clk) begin
      @(negedge clk);
    end
  endtask

  task automatic apply_entry(input entry_t e);
    wait_idle();
    @(negedge clk);
    cfg.clk_div = e.clk_div;
    cfg.tx_en   = e.tx_en;
    if (e.stall != 0) begin
      req_out_ready = 1'b0;
      rsp_out_ready = 1'b0;
    end
    fork
      begin
        if (e.both) begin
          fork
            send_flits(CHAN_REQ, e.burst);
            send_flits(CHAN_RSP, e.burst);
          join
        end else begin
          send_flits(e.chan, e.burst);
        end
      end
      begin
        repeat (e.stall) @(negedge clk);
        req_out_ready = 1'b1;
        rsp_out_ready = 1'b1;
      end
      begin
        // Flits wait at the inputs until tx_en comes back
        if (!e.tx_en) begin
          repeat (HoldCycles) @(negedge clk);
          cfg.tx_en = 1'b1;
        end
      end
    join
  endtask

  //////////////////////
  // Main sequence
  //////////////////////

  initial begin
    seed          = 32'h889f9b8e;
    reset         = 1'b1;
    cfg.clk_div   = clk_div_t'(1);
    cfg.tx_en     = 1'b1;
    req_in        = '0;
    rsp_in        = '0;
    req_out_ready = 1'b1;
    rsp_out_ready = 1'b1;
    fill_table();
    repeat (ResetCycles) @(negedge clk);
    reset = 1'b0;
    for (idx = 0; idx < NumEntries; idx++) begin
      apply_entry(stim[idx]);
    end
    wait_idle();
    repeat (4) @(negedge clk);
    $display("Flits accepted %0d, delivered %0d, errors %0d", accepted, delivered, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout after %0d ns, the link stopped delivering flits", TimeoutNs);
    $display("Flits accepted %0d, delivered %0d, errors %0d", accepted, delivered, errors);
    $display("Checks failed");
    $finish;
  end

endmodule

// ==== verif/sl_checker.sv ====
/*
 * Scoreboard for the serial link testbench
 * Queues accepted flits per channel and compares every output transfer,
 * and watches arbitration, output stalls, tx_en and forwarded clock phases
 */

module sl_checker
  import sl_flit_pkg::*;
  import sl_link_pkg::*;
#(
  parameter int NumLanes = 4
) (
  input  logic      clk_i,
  input  logic      reset_i,
  input  phy_cfg_t  cfg_i,
  // Network inputs of the DUT
  input  noc_chan_t in_req_i,
  input  noc_chan_t in_rsp_i,
  input  logic      in_req_ready_i,
  input  logic      in_rsp_ready_i,
  // Network outputs of the DUT
  input  noc_chan_t out_req_i,
  input  noc_chan_t out_rsp_i,
  input  logic      out_req_ready_i,
  input  logic      out_rsp_ready_i,
  input  logic      lane_clk_i,
  output int        errors_o,
  output int        accepted_o,
  output int        delivered_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int NumBeats = PayloadWidth / (2 * NumLanes);

  flit_t req_q[$];
  flit_t rsp_q[$];
  chan_e last_chan;
  logic  served_once;
  logic  req_hold;
  logic  rsp_hold;
  flit_t req_held;
  flit_t rsp_held;
  logic  clk_prev;
  int    run_len;
  int    beat_idx;

  initial begin
    errors_o    = 0;
    accepted_o  = 0;
    delivered_o = 0;
    served_once = 1'b0;
    last_chan   = CHAN_REQ;
  end

  task automatic report_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
    $display("ERR %0t %s expected %0h got %0h", $time, sig, exp, got);
    errors_o++;
  endtask

  task automatic report_text(input string msg);
    $display("%0t: %s", $time, msg);
    errors_o++;
  endtask

  ////////////////////
  // Input side
  ////////////////////

  task automatic check_inputs();
    logic fire_req;
    logic fire_rsp;
    fire_req = in_req_i.valid && in_req_ready_i;
    fire_rsp = in_rsp_i.valid && in_rsp_ready_i;
    if (fire_req && fire_rsp) begin
      report_text("both input channels were accepted in the same cycle");
    end
    // With both waiting, the channel not served last must win
    if (in_req_i.valid && in_rsp_i.valid && served_once) begin
      if ((fire_req && last_chan == CHAN_REQ) || (fire_rsp && last_chan == CHAN_RSP)) begin
        report_text("arbiter served the same channel twice while both were waiting");
      end
    end
    if (fire_req) begin
      req_q.push_back(in_req_i.data);
      accepted_o++;
      last_chan   = CHAN_REQ;
      served_once = 1'b1;
    end
    if (fire_rsp) begin
      rsp_q.push_back(in_rsp_i.data);
      accepted_o++;
      last_chan   = CHAN_RSP;
      served_once = 1'b1;
    end
    if (!cfg_i.tx_en && (in_req_ready_i || in_rsp_ready_i)) begin
      report_text("an input ready was high while tx_en was low");
    end
    if (!cfg_i.tx_en && lane_clk_i) begin
      report_text("ddr_rcv_clk_o was high while tx_en was low");
    end
  endtask

  ////////////////////
  // Output side
  ////////////////////

  task automatic check_output(input chan_e ch, input flit_t got);
    flit_t exp;
    if (ch == CHAN_REQ) begin
      if (req_q.size() == 0) begin
        report_text("req_o delivered a flit that was never sent on req_i");
      end else begin
        exp = req_q.pop_front();
        if (got != exp) report_value("req_o.data", exp, got);
      end
    end else begin
      if (rsp_q.size() == 0) begin
        report_text("rsp_o delivered a flit that was never sent on rsp_i");
      end else begin
        exp = rsp_q.pop_front();
        if (got != exp) report_value("rsp_o.data", exp, got);
      end
    end
    delivered_o++;
  endtask

  task automatic check_outputs();
    // A stalled output keeps its valid and data
    if (req_hold) begin
      if (!out_req_i.valid) report_text("req_o.valid dropped before req_ready_i");
      else if (out_req_i.data != req_held) report_value("req_o.data", req_held, out_req_i.data);
    end
    if (rsp_hold) begin
      if (!out_rsp_i.valid) report_text("rsp_o.valid dropped before rsp_ready_i");
      else if (out_rsp_i.data != rsp_held) report_value("rsp_o.data", rsp_held, out_rsp_i.data);
    end
    if (out_req_i.valid && out_req_ready_i) check_output(CHAN_REQ, out_req_i.data);
    if (out_rsp_i.valid && out_rsp_ready_i) check_output(CHAN_RSP, out_rsp_i.data);
    req_hold = out_req_i.valid && !out_req_ready_i;
    req_held = out_req_i.data;
    rsp_hold = out_rsp_i.valid && !out_rsp_ready_i;
    rsp_held = out_rsp_i.data;
  endtask

  ////////////////////
  // Forwarded clock
  ////////////////////

  // Low phase before the first beat of a payload may be longer
  task automatic check_lane_clock();
    if (lane_clk_i == clk_prev) begin
      run_len++;
    end else begin
      if (clk_prev) begin
        if (run_len != int'(cfg_i.clk_div)) begin
          report_value("ddr_rcv_clk_o high phase", cfg_i.clk_div, run_len);
        end
      end else begin
        if (beat_idx != 0 && run_len != int'(cfg_i.clk_div)) begin
          report_value("ddr_rcv_clk_o low phase", cfg_i.clk_div, run_len);
        end else if (beat_idx == 0 && run_len < int'(cfg_i.clk_div)) begin
          report_text("ddr_rcv_clk_o low phase before a payload was shorter than clk_div");
        end
        beat_idx = (beat_idx + 1) % NumBeats;
      end
      clk_prev = lane_clk_i;
      run_len  = 1;
    end
  endtask

  always @(posedge clk_i) begin
    if (reset_i) begin
      clk_prev = 1'b0;
      run_len  = 0;
      beat_idx = 0;
      req_hold = 1'b0;
      rsp_hold = 1'b0;
    end else begin
      check_inputs();
      check_outputs();
      check_lane_clock();
    end
  end

endmodule

// ==== source/serial_link.sv ====
/*
 * Serial link top level
 * Request and response channels share one DDR lane bundle
 * with a forwarded clock
 */

module serial_link
  import sl_flit_pkg::*;
  import sl_link_pkg::*;
#(
  parameter int NumLanes    = 4,
  parameter int RxFifoDepth = 4
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  phy_cfg_t            cfg_i,
  // Network side
  input  noc_chan_t           req_i,
  input  noc_chan_t           rsp_i,
  output logic                req_ready_o,
  output logic                rsp_ready_o,
  output noc_chan_t           req_o,
  output noc_chan_t           rsp_o,
  input  logic                req_ready_i,
  input  logic                rsp_ready_i,
  // Lanes
  output logic                ddr_rcv_clk_o,
  output logic [NumLanes-1:0] ddr_o,
  input  logic                ddr_rcv_clk_i,
  input  logic [NumLanes-1:0] ddr_i
);

  payload_t              tx_payload;
  logic                  tx_valid;
  logic                  tx_ready;
  payload_t              rx_payload;
  logic                  rx_valid;
  payload_t              buf_payload;
  logic                  buf_valid;
  logic                  buf_ready;
  logic [2*NumLanes-1:0] beat;
  logic                  beat_valid;
  logic                  beat_ready;
  logic [2*NumLanes-1:0] rx_beat;
  logic                  rx_beat_valid;

  ////////////////////
  // Network
  ////////////////////

  sl_noc_bridge i_noc_bridge (
    .clk_i        ( clk_i       ),
    .reset_i      ( reset_i     ),
    .req_i        ( req_i       ),
    .rsp_i        ( rsp_i       ),
    .req_ready_o  ( req_ready_o ),
    .rsp_ready_o  ( rsp_ready_o ),
    .tx_payload_o ( tx_payload  ),
    .tx_valid_o   ( tx_valid    ),
    .tx_ready_i   ( tx_ready    ),
    .rx_payload_i ( buf_payload ),
    .rx_valid_i   ( buf_valid   ),
    .rx_ready_o   ( buf_ready   ),
    .req_o        ( req_o       ),
    .rsp_o        ( rsp_o       ),
    .req_ready_i  ( req_ready_i ),
    .rsp_ready_i  ( rsp_ready_i )
  );

  sl_rx_fifo #(
    .RxFifoDepth ( RxFifoDepth )
  ) i_rx_fifo (
    .clk_i       ( clk_i       ),
    .reset_i     ( reset_i     ),
    .push_i      ( rx_valid    ),
    .data_i      ( rx_payload  ),
    .pop_ready_i ( buf_ready   ),
    .data_o      ( buf_payload ),
    .valid_o     ( buf_valid   )
  );

  ////////////////////
  // Link and lanes
  ////////////////////

  sl_data_link #(
    .NumLanes ( NumLanes )
  ) i_data_link (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .cfg_tx_en_i     ( cfg_i.tx_en   ),
    .tx_payload_i    ( tx_payload    ),
    .tx_valid_i      ( tx_valid      ),
    .tx_ready_o      ( tx_ready      ),
    .beat_o          ( beat          ),
    .beat_valid_o    ( beat_valid    ),
    .beat_ready_i    ( beat_ready    ),
    .rx_beat_i       ( rx_beat       ),
    .rx_beat_valid_i ( rx_beat_valid ),
    .rx_payload_o    ( rx_payload    ),
    .rx_valid_o      ( rx_valid      )
  );

  sl_physical #(
    .NumLanes ( NumLanes )
  ) i_physical (
    .clk_i           ( clk_i         ),
    .reset_i         ( reset_i       ),
    .clk_div_i       ( cfg_i.clk_div ),
    .beat_i          ( beat          ),
    .beat_valid_i    ( beat_valid    ),
    .beat_ready_o    ( beat_ready    ),
    .ddr_rcv_clk_o   ( ddr_rcv_clk_o ),
    .ddr_o           ( ddr_o         ),
    .ddr_rcv_clk_i   ( ddr_rcv_clk_i ),
    .ddr_i           ( ddr_i         ),
    .rx_beat_o       ( rx_beat       ),
    .rx_beat_valid_o ( rx_beat_valid )
  );

endmodule

// ==== source/sl_physical.sv ====
/*
 * Physical layer of the serial link
 * Sends each beat as two DDR half-beats with a divided forwarded clock,
 * and rebuilds beats from the edges of the received clock
 */

module sl_physical
  import sl_link_pkg::*;
#(
  parameter int NumLanes = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  clk_div_t              clk_div_i,
  // Beats from the data link
  input  logic [2*NumLanes-1:0] beat_i,
  input  logic                  beat_valid_i,
  output logic                  beat_ready_o,
  // Lanes out
  output logic                  ddr_rcv_clk_o,
  output logic [NumLanes-1:0]   ddr_o,
  // Lanes in
  input  logic                  ddr_rcv_clk_i,
  input  logic [NumLanes-1:0]   ddr_i,
  // Beats to the data link
  output logic [2*NumLanes-1:0] rx_beat_o,
  output logic                  rx_beat_valid_o
);

  ////////////////////
  // Transmit
  ////////////////////

  tx_state_e state_q;
  tx_state_e state_d;
  clk_div_t  phase_cnt_q;
  clk_div_t  phase_cnt_d;
  logic      phase_last;

  assign phase_last = (phase_cnt_q == clk_div_i - clk_div_t'(1));

  always_comb begin
    state_d     = state_q;
    phase_cnt_d = phase_cnt_q + clk_div_t'(1);
    unique case (state_q)
      TX_IDLE: begin
        phase_cnt_d = '0;
        if (beat_valid_i) begin
          state_d = TX_LOW;
        end
      end
      TX_LOW: begin
        // Data link had no further beat after the last high phase
        if (!beat_valid_i) begin
          state_d     = TX_IDLE;
          phase_cnt_d = '0;
        end else if (phase_last) begin
          state_d     = TX_HIGH;
          phase_cnt_d = '0;
        end
      end
      TX_HIGH: begin
        if (phase_last) begin
          state_d     = TX_LOW;
          phase_cnt_d = '0;
        end
      end
      default: begin
        state_d     = TX_IDLE;
        phase_cnt_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q     <= TX_IDLE;
      phase_cnt_q <= '0;
    end else begin
      state_q     <= state_d;
      phase_cnt_q <= phase_cnt_d;
    end
  end

  assign beat_ready_o  = (state_q == TX_HIGH) && phase_last;
  assign ddr_rcv_clk_o = (state_q == TX_HIGH);
  // Lower half while the clock is low, upper half while it is high
  assign ddr_o = (state_q == TX_HIGH) ? beat_i[2*NumLanes-1:NumLanes] : beat_i[NumLanes-1:0];

  assert property (@(posedge clk_i) disable iff (reset_i) state_q != TX_IDLE |-> clk_div_i != '0)
    else $error("Zero clock divider while transmitting");

  ////////////////////
  // Receive
  ////////////////////

  logic                rcv_clk_q;
  logic                rcv_clk_d1_q;
  logic [NumLanes-1:0] ddr_q;
  logic [NumLanes-1:0] ddr_d1_q;
  logic [NumLanes-1:0] lower_q;
  logic [NumLanes-1:0] upper_q;
  logic                rx_valid_q;
  logic                rise;
  logic                fall;

  assign rise = rcv_clk_q && !rcv_clk_d1_q;
  assign fall = !rcv_clk_q && rcv_clk_d1_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rcv_clk_q    <= 1'b0;
      rcv_clk_d1_q <= 1'b0;
      rx_valid_q   <= 1'b0;
    end else begin
      rcv_clk_q    <= ddr_rcv_clk_i;
      rcv_clk_d1_q <= rcv_clk_q;
      rx_valid_q   <= fall;
    end
  end

  // The lanes one cycle before an edge hold the half-beat of the old phase
  always_ff @(posedge clk_i) begin
    ddr_q    <= ddr_i;
    ddr_d1_q <= ddr_q;
    if (rise) begin
      lower_q <= ddr_d1_q;
    end
    if (fall) begin
      upper_q <= ddr_d1_q;
    end
  end

  assign rx_beat_o       = {upper_q, lower_q};
  assign rx_beat_valid_o = rx_valid_q;

endmodule

// ==== source/sl_rx_fifo.sv ====
/*
 * Receive buffer of the serial link
 * Circular payload buffer that absorbs back-pressure on the outputs
 */

module sl_rx_fifo
  import sl_flit_pkg::*;
#(
  parameter int RxFifoDepth = 4
) (
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_ready_i,
  output payload_t data_o,
  output logic     valid_o
);

  localparam int PtrWidth = (RxFifoDepth > 1) ? $clog2(RxFifoDepth) : 1;
  localparam int CntWidth = $clog2(RxFifoDepth + 1);
  localparam logic [PtrWidth-1:0] LastPtr = PtrWidth'(RxFifoDepth - 1);
  localparam logic [CntWidth-1:0] FullCnt = CntWidth'(RxFifoDepth);

  payload_t            mem_q [RxFifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                pop;

  assign valid_o = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign pop     = valid_o && pop_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // No credits on the link, so the far sender cannot see this level
  assert property (@(posedge clk_i) disable iff (reset_i) push_i |-> count_q != FullCnt)
    else $error("Receive buffer overflow");

endmodule

// ==== source/sl_data_link.sv ====
/*
 * Data link layer of the serial link
 * Cuts each payload into lane-wide beats, low beat first,
 * and reassembles received beats into whole payloads
 */

module sl_data_link
  import sl_flit_pkg::*;
#(
  parameter int NumLanes = 4
) (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  cfg_tx_en_i,
  // Payloads from the bridge
  input  payload_t              tx_payload_i,
  input  logic                  tx_valid_i,
  output logic                  tx_ready_o,
  // Beats to the physical layer
  output logic [2*NumLanes-1:0] beat_o,
  output logic                  beat_valid_o,
  input  logic                  beat_ready_i,
  // Beats from the physical layer
  input  logic [2*NumLanes-1:0] rx_beat_i,
  input  logic                  rx_beat_valid_i,
  // Payloads to the receive buffer
  output payload_t              rx_payload_o,
  output logic                  rx_valid_o
);

  localparam int BeatWidth = 2 * NumLanes;
  localparam int NumBeats  = PayloadWidth / BeatWidth;
  localparam int CntWidth  = (NumBeats > 1) ? $clog2(NumBeats) : 1;
  localparam logic [CntWidth-1:0] LastBeat = CntWidth'(NumBeats - 1);

  if (PayloadWidth % BeatWidth != 0) begin : gen_width_check
    $error("Payload width must be a multiple of the beat width");
  end

  ////////////////////
  // Transmit
  ////////////////////

  logic                    tx_busy_q;
  logic [CntWidth-1:0]     tx_cnt_q;
  logic [PayloadWidth-1:0] tx_shift_q;
  logic                    tx_fire;
  logic                    tx_step;

  assign tx_ready_o = !tx_busy_q && cfg_tx_en_i;
  assign tx_fire    = tx_valid_i && tx_ready_o;
  assign tx_step    = tx_busy_q && beat_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      tx_busy_q <= 1'b0;
      tx_cnt_q  <= '0;
    end else if (tx_fire) begin
      tx_busy_q <= 1'b1;
      tx_cnt_q  <= '0;
    end else if (tx_step) begin
      tx_cnt_q <= tx_cnt_q + 1'b1;
      // Idle again right after the last beat leaves
      if (tx_cnt_q == LastBeat) begin
        tx_busy_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_fire) begin
      tx_shift_q <= tx_payload_i;
    end else if (tx_step) begin
      tx_shift_q <= tx_shift_q >> BeatWidth;
    end
  end

  assign beat_o       = tx_shift_q[BeatWidth-1:0];
  assign beat_valid_o = tx_busy_q;

  ////////////////////
  // Receive
  ////////////////////

  logic [CntWidth-1:0]               rx_cnt_q;
  logic [PayloadWidth-1:0]           rx_shift_q;
  logic [PayloadWidth+BeatWidth-1:0] rx_next;
  logic                              rx_valid_q;

  // New beat enters at the top, so the first one ends up lowest
  assign rx_next = {rx_beat_i, rx_shift_q};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rx_cnt_q   <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= rx_beat_valid_i && (rx_cnt_q == LastBeat);
      if (rx_beat_valid_i) begin
        rx_cnt_q <= (rx_cnt_q == LastBeat) ? '0 : rx_cnt_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_beat_valid_i) begin
      rx_shift_q <= rx_next[PayloadWidth+BeatWidth-1:BeatWidth];
    end
  end

  assign rx_payload_o = payload_t'(rx_shift_q);
  assign rx_valid_o   = rx_valid_q;

endmodule

// ==== source/sl_noc_bridge.sv ====
/*
 * NoC bridge of the serial link
 * Round-robin choice between request and response flits, tagged
 * with their channel, and steering of received payloads by that tag
 */

module sl_noc_bridge
  import sl_flit_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  // Network inputs
  input  noc_chan_t req_i,
  input  noc_chan_t rsp_i,
  output logic      req_ready_o,
  output logic      rsp_ready_o,
  // Towards the data link
  output payload_t  tx_payload_o,
  output logic      tx_valid_o,
  input  logic      tx_ready_i,
  // From the receive buffer
  input  payload_t  rx_payload_i,
  input  logic      rx_valid_i,
  output logic      rx_ready_o,
  // Network outputs
  output noc_chan_t req_o,
  output noc_chan_t rsp_o,
  input  logic      req_ready_i,
  input  logic      rsp_ready_i
);

  ////////////////////
  // Transmit
  ////////////////////

  chan_e last_q;
  logic  pick_rsp;
  logic  tx_fire;

  // Response wins when alone, or when requests were served last
  assign pick_rsp = rsp_i.valid && (!req_i.valid || last_q == CHAN_REQ);

  assign tx_valid_o        = req_i.valid || rsp_i.valid;
  assign tx_payload_o.chan = pick_rsp ? CHAN_RSP : CHAN_REQ;
  assign tx_payload_o.data = pick_rsp ? rsp_i.data : req_i.data;

  assign req_ready_o = tx_ready_i && req_i.valid && !pick_rsp;
  assign rsp_ready_o = tx_ready_i && pick_rsp;

  assign tx_fire = tx_valid_o && tx_ready_i;

  // Starts out favouring requests
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      last_q <= CHAN_RSP;
    end else if (tx_fire) begin
      last_q <= tx_payload_o.chan;
    end
  end

  ////////////////////
  // Receive
  ////////////////////

  assign req_o.valid = rx_valid_i && (rx_payload_i.chan == CHAN_REQ);
  assign req_o.data  = rx_payload_i.data;
  assign rsp_o.valid = rx_valid_i && (rx_payload_i.chan == CHAN_RSP);
  assign rsp_o.data  = rx_payload_i.data;

  // Buffer head leaves only when its own channel is ready
  assign rx_ready_o = (rx_payload_i.chan == CHAN_REQ) ? req_ready_i : rsp_ready_i;

  // A waiting request keeps its flit until it is taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_i.valid && !req_ready_o |=> req_i.valid && $stable(req_i.data))
    else $error("req_i changed while waiting for ready");

endmodule

// ==== source/sl_link_pkg.sv ====
/*
 * Physical-layer types of the serial link
 * Configuration of the forwarded clock and the transmitter states
 */

package sl_link_pkg;

  //////////////////////
  // Configuration
  //////////////////////

  localparam int ClkDivWidth = 8;

  // Half period of the forwarded clock, in clk_i cycles
  typedef logic [ClkDivWidth-1:0] clk_div_t;

  typedef struct packed {
    clk_div_t clk_div;
    logic     tx_en;
  } phy_cfg_t;

  //////////////////////
  // Transmitter FSM
  //////////////////////

  // Idle keeps the forwarded clock low
  // Low and high each last clk_div cycles per beat
  typedef enum logic [1:0] {
    TX_IDLE = 2'b00,
    TX_LOW  = 2'b01,
    TX_HIGH = 2'b10
  } tx_state_e;

endpackage

// ==== source/sl_flit_pkg.sv ====
/*
 * Network-side types of the serial link
 * Flits, channel tags and the tagged payload that crosses the lanes
 */

package sl_flit_pkg;

  // One flit of network data
  localparam int FlitWidth = 31;

  typedef logic [FlitWidth-1:0] flit_t;

  // Channel tag carried with each payload
  typedef enum logic {
    CHAN_REQ = 1'b0,
    CHAN_RSP = 1'b1
  } chan_e;

  // Tagged flit as seen by the data link
  typedef struct packed {
    chan_e chan;
    flit_t data;
  } payload_t;

  localparam int PayloadWidth = $bits(payload_t);

  // One flit stream, paired with a separate ready
  typedef struct packed {
    logic  valid;
    flit_t data;
  } noc_chan_t;

endpackage
